//--- bus_defs.svh
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// data and address width
`define BUS_XLEN 32

// mtime, low and high word
`define BUS_CLINT_ADDR    32'h0200_bff8
`define BUS_CLINT_ADDR_UP 32'h0200_bffc

// watchdog cycles per request
`define BUS_TIMEOUT_CYCLES 200

`endif

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_t;

  // bytes per beat, log2
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } axi_size_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

endpackage

`default_nettype wire

//--- mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // same codes as the axi size field
  typedef enum logic [1:0] {
    WIDTH_BYTE = 2'b00,
    WIDTH_HALF = 2'b01,
    WIDTH_WORD = 2'b10
  } access_width_t;

  typedef enum logic {
    TARGET_MEMORY = 1'b0,
    TARGET_TIMER  = 1'b1
  } target_t;

  function automatic access_width_t decode_width(logic [7:0] strb);
    case (strb)
      8'h03:   return WIDTH_HALF;
      8'h0f:   return WIDTH_WORD;
      default: return WIDTH_BYTE;  // odd strobes fall back to byte
    endcase
  endfunction

endpackage

`default_nettype wire

//--- clint.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_defs.svh"

module clint (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic [`BUS_XLEN-1:0] araddr,
  input  wire logic                 arvalid,
  output logic      [`BUS_XLEN-1:0] rdata,
  output logic                      rvalid
);
  logic [63:0] mtime;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= arvalid;  // one cycle response
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid) begin
      rdata <= (araddr == `BUS_CLINT_ADDR_UP) ? mtime[63:32] : mtime[31:0];
    end
  end

  // the arbiter only forwards decoded timer loads
  assert property (@(posedge clock) disable iff (reset)
    arvalid |-> (araddr == `BUS_CLINT_ADDR || araddr == `BUS_CLINT_ADDR_UP))
    else $error("clint request outside the timer words: %h", araddr);

endmodule

`default_nettype wire

//--- read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_defs.svh"

module read_arbiter (
  input  wire logic                     clock,
  input  wire logic                     reset,
  // fetch
  input  wire logic [`BUS_XLEN-1:0]     ifu_araddr,
  input  wire logic                     ifu_arvalid,
  input  wire logic                     ifu_lock,
  input  wire logic                     ifu_ready,
  output logic                          bus_ifu_ready,
  output logic      [`BUS_XLEN-1:0]     ifu_rdata,
  output logic                          ifu_rvalid,
  // load
  input  wire logic [`BUS_XLEN-1:0]     lsu_araddr,
  input  wire logic                     lsu_arvalid,
  input  wire logic [7:0]               lsu_rstrb,
  output logic      [`BUS_XLEN-1:0]     lsu_rdata,
  output logic                          lsu_rvalid,
  // axi read channels
  output logic      [`BUS_XLEN-1:0]     araddr,
  output logic                          arvalid,
  input  wire logic                     arready,
  output axi_pkg::axi_size_t            arsize,
  output axi_pkg::axi_burst_t           arburst,
  output logic      [7:0]               arlen,
  output logic      [3:0]               arid,
  input  wire logic [`BUS_XLEN-1:0]     rdata,
  input  wire axi_pkg::axi_resp_t       rresp,
  input  wire logic                     rvalid,
  output logic                          rready,
  // clint
  output logic                          clint_arvalid,
  output logic      [`BUS_XLEN-1:0]     clint_araddr,
  input  wire logic [`BUS_XLEN-1:0]     clint_rdata,
  input  wire logic                     clint_rvalid
);
  typedef enum logic [1:0] {
    FETCH_ADDR,  // also the idle state
    FETCH_DATA,
    LOAD_ADDR,
    LOAD_DATA
  } state_t;

  state_t               state;
  logic                 fetch_req;
  mem_map_pkg::target_t load_target;
  mem_map_pkg::target_t data_target;  // where the issued load returns from
  axi_pkg::axi_size_t   load_size;

  assign fetch_req = ifu_arvalid && ifu_ready;

  assign load_target = (lsu_araddr == `BUS_CLINT_ADDR || lsu_araddr == `BUS_CLINT_ADDR_UP) ?
                       mem_map_pkg::TARGET_TIMER : mem_map_pkg::TARGET_MEMORY;

  assign load_size = axi_pkg::axi_size_t'({1'b0, mem_map_pkg::decode_width(lsu_rstrb)});

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= FETCH_ADDR;
      data_target <= mem_map_pkg::TARGET_MEMORY;
    end else begin
      case (state)
        FETCH_ADDR: begin
          if (fetch_req) begin
            if (arready) begin
              state <= FETCH_DATA;
            end
          end else if (!ifu_lock && lsu_arvalid) begin
            state <= LOAD_ADDR;
          end
        end
        FETCH_DATA: begin
          if (rvalid) begin
            state <= FETCH_ADDR;
          end
        end
        LOAD_ADDR: begin
          if (load_target == mem_map_pkg::TARGET_TIMER) begin
            state       <= LOAD_DATA;  // clint takes it without a ready
            data_target <= mem_map_pkg::TARGET_TIMER;
          end else if (arready) begin
            state       <= LOAD_DATA;
            data_target <= mem_map_pkg::TARGET_MEMORY;
          end
        end
        LOAD_DATA: begin
          if (lsu_rvalid) begin
            state <= FETCH_ADDR;
          end
        end
        default: state <= FETCH_ADDR;
      endcase
    end
  end

  assign bus_ifu_ready = (state == FETCH_ADDR);

  // address channel
  assign arvalid = (state == FETCH_ADDR && fetch_req) ||
                   (state == LOAD_ADDR && load_target == mem_map_pkg::TARGET_MEMORY);
  assign araddr  = (state == LOAD_ADDR) ? lsu_araddr : ifu_araddr;
  assign arsize  = (state == LOAD_ADDR) ? load_size : axi_pkg::SIZE_WORD;
  assign arburst = axi_pkg::BURST_FIXED;
  assign arlen   = 8'h00;  // single beat
  assign arid    = 4'h0;
  assign rready  = 1'b1;

  assign clint_arvalid = (state == LOAD_ADDR) && (load_target == mem_map_pkg::TARGET_TIMER);
  assign clint_araddr  = lsu_araddr;

  // return routing
  assign ifu_rvalid = (state == FETCH_DATA) && rvalid;
  assign ifu_rdata  = rdata;
  assign lsu_rvalid = (state == LOAD_DATA) &&
                      ((data_target == mem_map_pkg::TARGET_TIMER) ? clint_rvalid : rvalid);
  assign lsu_rdata  = (data_target == mem_map_pkg::TARGET_TIMER) ? clint_rdata : rdata;

  assert property (@(posedge clock) disable iff (reset)
    rvalid |-> rresp == axi_pkg::RESP_OKAY)
    else $error("read response %0d is not OKAY", rresp);

  // the slave may stall the address as long as it likes
  assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped before arready");

endmodule

`default_nettype wire

//--- store_channel.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_defs.svh"

module store_channel (
  input  wire logic                 clock,
  input  wire logic                 reset,
  // store from the core
  input  wire logic [`BUS_XLEN-1:0] lsu_awaddr,
  input  wire logic                 lsu_awvalid,
  input  wire logic [`BUS_XLEN-1:0] lsu_wdata,
  input  wire logic [7:0]           lsu_wstrb,
  input  wire logic                 lsu_wvalid,
  output logic                      lsu_wready,
  // axi write channels
  output logic      [`BUS_XLEN-1:0] awaddr,
  output logic                      awvalid,
  input  wire logic                 awready,
  output axi_pkg::axi_size_t        awsize,
  output axi_pkg::axi_burst_t       awburst,
  output logic      [7:0]           awlen,
  output logic      [3:0]           awid,
  output logic      [`BUS_XLEN-1:0] wdata,
  output logic      [3:0]           wstrb,
  output logic                      wlast,
  output logic                      wvalid,
  input  wire logic                 wready,
  input  wire axi_pkg::axi_resp_t   bresp,
  input  wire logic                 bvalid,
  output logic                      bready
);
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    RESP
  } state_t;

  state_t state;
  logic   aw_done;
  logic   w_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (lsu_awvalid) begin
            state   <= SEND;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        SEND: begin
          if (awvalid && awready) begin
            aw_done <= 1'b1;
          end
          if (wvalid && wready) begin
            w_done <= 1'b1;
          end
          if (lsu_wready) begin
            state <= RESP;
          end
        end
        RESP: state <= IDLE;  // lets the core drop its request
        default: state <= IDLE;
      endcase
    end
  end

  assign awvalid = (state == SEND) && lsu_wvalid && !aw_done;
  assign wvalid  = (state == SEND) && lsu_wvalid && !w_done;
  assign lsu_wready = (state == SEND) && aw_done && w_done && bvalid;

  assign awaddr  = lsu_awaddr;
  assign awsize  = axi_pkg::axi_size_t'({1'b0, mem_map_pkg::decode_width(lsu_wstrb)});
  assign awburst = axi_pkg::BURST_FIXED;
  assign awlen   = 8'h00;
  assign awid    = 4'h0;

  // move the bytes to their lanes
  assign wdata  = lsu_wdata << {lsu_awaddr[1:0], 3'b000};
  assign wstrb  = lsu_wstrb[3:0] << lsu_awaddr[1:0];
  assign wlast  = 1'b1;  // single beat
  assign bready = 1'b1;

  assert property (@(posedge clock) disable iff (reset)
    bvalid |-> bresp == axi_pkg::RESP_OKAY)
    else $error("write response %0d is not OKAY", bresp);

endmodule

`default_nettype wire

//--- bus_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_defs.svh"

module bus_top (
  input  wire logic                 clock,
  input  wire logic                 reset,
  // fetch
  input  wire logic [`BUS_XLEN-1:0] ifu_araddr,
  input  wire logic                 ifu_arvalid,
  input  wire logic                 ifu_lock,
  input  wire logic                 ifu_ready,
  output logic                      bus_ifu_ready,
  output logic      [`BUS_XLEN-1:0] ifu_rdata,
  output logic                      ifu_rvalid,
  // load
  input  wire logic [`BUS_XLEN-1:0] lsu_araddr,
  input  wire logic                 lsu_arvalid,
  input  wire logic [7:0]           lsu_rstrb,
  output logic      [`BUS_XLEN-1:0] lsu_rdata,
  output logic                      lsu_rvalid,
  // store
  input  wire logic [`BUS_XLEN-1:0] lsu_awaddr,
  input  wire logic                 lsu_awvalid,
  input  wire logic [`BUS_XLEN-1:0] lsu_wdata,
  input  wire logic [7:0]           lsu_wstrb,
  input  wire logic                 lsu_wvalid,
  output logic                      lsu_wready,
  // axi master
  output logic      [`BUS_XLEN-1:0] araddr,
  output logic                      arvalid,
  input  wire logic                 arready,
  output axi_pkg::axi_size_t        arsize,
  output axi_pkg::axi_burst_t       arburst,
  output logic      [7:0]           arlen,
  output logic      [3:0]           arid,
  input  wire logic [`BUS_XLEN-1:0] rdata,
  input  wire axi_pkg::axi_resp_t   rresp,
  input  wire logic                 rvalid,
  output logic                      rready,
  output logic      [`BUS_XLEN-1:0] awaddr,
  output logic                      awvalid,
  input  wire logic                 awready,
  output axi_pkg::axi_size_t        awsize,
  output axi_pkg::axi_burst_t       awburst,
  output logic      [7:0]           awlen,
  output logic      [3:0]           awid,
  output logic      [`BUS_XLEN-1:0] wdata,
  output logic      [3:0]           wstrb,
  output logic                      wlast,
  output logic                      wvalid,
  input  wire logic                 wready,
  input  wire axi_pkg::axi_resp_t   bresp,
  input  wire logic                 bvalid,
  output logic                      bready
);
  logic                 clint_arvalid;
  logic [`BUS_XLEN-1:0] clint_araddr;
  logic [`BUS_XLEN-1:0] clint_rdata;
  logic                 clint_rvalid;

  read_arbiter u_read_arbiter (
    .clock, .reset,
    .ifu_araddr, .ifu_arvalid, .ifu_lock, .ifu_ready,
    .bus_ifu_ready, .ifu_rdata, .ifu_rvalid,
    .lsu_araddr, .lsu_arvalid, .lsu_rstrb, .lsu_rdata, .lsu_rvalid,
    .araddr, .arvalid, .arready, .arsize, .arburst, .arlen, .arid,
    .rdata, .rresp, .rvalid, .rready,
    .clint_arvalid, .clint_araddr, .clint_rdata, .clint_rvalid
  );

  // timer loads stop here
  clint u_clint (
    .clock   (clock),
    .reset   (reset),
    .araddr  (clint_araddr),
    .arvalid (clint_arvalid),
    .rdata   (clint_rdata),
    .rvalid  (clint_rvalid)
  );

  store_channel u_store_channel (
    .clock, .reset,
    .lsu_awaddr, .lsu_awvalid, .lsu_wdata, .lsu_wstrb, .lsu_wvalid, .lsu_wready,
    .awaddr, .awvalid, .awready, .awsize, .awburst, .awlen, .awid,
    .wdata, .wstrb, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

endmodule

`default_nettype wire

//--- axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_defs.svh"

module axi_mem_model (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic [1:0]           delay_max,  // longest random wait in cycles
  // read channels
  input  wire logic [`BUS_XLEN-1:0] araddr,
  input  wire logic                 arvalid,
  output logic                      arready,
  output logic      [`BUS_XLEN-1:0] rdata,
  output axi_pkg::axi_resp_t        rresp,
  output logic                      rvalid,
  input  wire logic                 rready,
  // write channels
  input  wire logic [`BUS_XLEN-1:0] awaddr,
  input  wire logic                 awvalid,
  output logic                      awready,
  input  wire logic [`BUS_XLEN-1:0] wdata,
  input  wire logic [3:0]           wstrb,
  input  wire logic                 wvalid,
  output logic                      wready,
  output axi_pkg::axi_resp_t        bresp,
  output logic                      bvalid,
  input  wire logic                 bready
);
  logic [7:0]  mem [0:65535];  // 64 KiB, upper address bits ignored
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [1:0]  b_wait;
  logic        r_pending;
  logic [15:0] r_addr;
  logic [15:0] w_addr;
  logic        aw_got;
  logic        w_got;
  logic [31:0] w_data;
  logic [3:0]  w_strb;

  function automatic logic [31:0] fill_word(input logic [15:0] addr);
    return {addr, ~addr} ^ 32'h3c5a_96e1;
  endfunction

  function automatic logic [1:0] pick_delay(input logic [1:0] limit);
    logic [31:0] r;
    r = $urandom_range({30'd0, limit}, 0);
    return r[1:0];
  endfunction

  function automatic logic [31:0] read_word(input logic [15:0] addr);
    logic [15:0] a;
    a = {addr[15:2], 2'b00};
    return {mem[a + 16'd3], mem[a + 16'd2], mem[a + 16'd1], mem[a]};
  endfunction

  initial begin
    logic [31:0] w;
    for (int a = 0; a < 65536; a += 4) begin
      w = fill_word(a[15:0]);
      mem[a[15:0]]         = w[7:0];
      mem[a[15:0] + 16'd1] = w[15:8];
      mem[a[15:0] + 16'd2] = w[23:16];
      mem[a[15:0] + 16'd3] = w[31:24];
    end
  end

  assign rresp = axi_pkg::RESP_OKAY;
  assign bresp = axi_pkg::RESP_OKAY;

  always @(posedge clock) begin
    if (reset) begin
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      r_pending <= 1'b0;
      ar_wait   <= 2'd0;
      r_wait    <= 2'd0;
    end else begin
      if (rvalid && rready) rvalid <= 1'b0;
      if (arvalid && arready) begin
        arready   <= 1'b0;
        r_pending <= 1'b1;
        r_addr    <= araddr[15:0];
        r_wait    <= pick_delay(delay_max);
        ar_wait   <= pick_delay(delay_max);
      end else if (arvalid && !r_pending && !rvalid) begin
        if (ar_wait == 2'd0) arready <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
      if (r_pending) begin
        if (r_wait == 2'd0) begin
          rvalid    <= 1'b1;
          rdata     <= read_word(r_addr);
          r_pending <= 1'b0;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      aw_wait <= 2'd0;
      w_wait  <= 2'd0;
      b_wait  <= 2'd0;
    end else begin
      if (bvalid && bready) bvalid <= 1'b0;
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_got  <= 1'b1;
        w_addr  <= awaddr[15:0];
        aw_wait <= pick_delay(delay_max);
      end else if (awvalid && !aw_got) begin
        if (aw_wait == 2'd0) awready <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end
      if (wvalid && wready) begin
        wready <= 1'b0;
        w_got  <= 1'b1;
        w_data <= wdata;
        w_strb <= wstrb;
        w_wait <= pick_delay(delay_max);
      end else if (wvalid && !w_got) begin
        if (w_wait == 2'd0) wready <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end
      // response once both halves are in
      if (aw_got && w_got) begin
        if (b_wait == 2'd0) begin
          bvalid <= 1'b1;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
          b_wait <= pick_delay(delay_max);
          for (int i = 0; i < 4; i++) begin
            if (w_strb[i]) mem[{w_addr[15:2], 2'(i)}] <= w_data[i*8 +: 8];
          end
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_defs.svh"

module tb_bus;
  localparam logic [31:0] MEM_BASE   = 32'h8000_0000;
  localparam int          TOTAL_REQS = 430;  // request total of all tests rounded up
  localparam logic [7:0]  LOAD_STRB [3] = '{8'h01, 8'h03, 8'h0f};
  localparam axi_pkg::axi_size_t LOAD_SIZE [3] =
    '{axi_pkg::SIZE_BYTE, axi_pkg::SIZE_HALF, axi_pkg::SIZE_WORD};

  logic                clock = 1'b0;
  logic                reset;
  logic [1:0]          delay_max;
  logic [31:0]         ifu_araddr;
  logic                ifu_arvalid;
  logic                ifu_lock;
  logic                ifu_ready;
  logic                bus_ifu_ready;
  logic [31:0]         ifu_rdata;
  logic                ifu_rvalid;
  logic [31:0]         lsu_araddr;
  logic                lsu_arvalid;
  logic [7:0]          lsu_rstrb;
  logic [31:0]         lsu_rdata;
  logic                lsu_rvalid;
  logic [31:0]         lsu_awaddr;
  logic                lsu_awvalid;
  logic [31:0]         lsu_wdata;
  logic [7:0]          lsu_wstrb;
  logic                lsu_wvalid;
  logic                lsu_wready;
  logic [31:0]         araddr;
  logic                arvalid;
  logic                arready;
  axi_pkg::axi_size_t  arsize;
  axi_pkg::axi_burst_t arburst;
  logic [7:0]          arlen;
  logic [3:0]          arid;
  logic [31:0]         rdata;
  axi_pkg::axi_resp_t  rresp;
  logic                rvalid;
  logic                rready;
  logic [31:0]         awaddr;
  logic                awvalid;
  logic                awready;
  axi_pkg::axi_size_t  awsize;
  axi_pkg::axi_burst_t awburst;
  logic [7:0]          awlen;
  logic [3:0]          awid;
  logic [31:0]         wdata;
  logic [3:0]          wstrb;
  logic                wlast;
  logic                wvalid;
  logic                wready;
  axi_pkg::axi_resp_t  bresp;
  logic                bvalid;
  logic                bready;

  logic [7:0]         ref_mem [0:65535];
  int                 errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 ar_count = 0;
  int                 ifu_rcount = 0;
  int                 lsu_rcount = 0;
  int                 wready_count = 0;
  axi_pkg::axi_size_t ar_size_seen;
  axi_pkg::axi_size_t aw_size_seen;
  logic [3:0]         wstrb_seen;
  logic [31:0]        ar_addr_q [$];
  logic               ar_open;
  logic               aw_open;
  logic               w_open;

  bus_top UUT (.*);

  axi_mem_model mem_model (.*);

  always #10 clock = ~clock;

  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [31:0] pattern_word(input logic [15:0] addr);
    return {addr, ~addr} ^ 32'h3c5a_96e1;
  endfunction

  task automatic load_reference();
    logic [31:0] w;
    for (int a = 0; a < 65536; a += 4) begin
      w = pattern_word(a[15:0]);
      ref_mem[a[15:0]]         = w[7:0];
      ref_mem[a[15:0] + 16'd1] = w[15:8];
      ref_mem[a[15:0] + 16'd2] = w[23:16];
      ref_mem[a[15:0] + 16'd3] = w[31:24];
    end
  endtask

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [15:0] a;
    a = {addr[15:2], 2'b00};
    return {ref_mem[a + 16'd3], ref_mem[a + 16'd2], ref_mem[a + 16'd1], ref_mem[a]};
  endfunction

  // bytes land only in the enabled lanes
  task automatic ref_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] lanes);
    logic [31:0] shifted;
    logic [15:0] a;
    shifted = data << (addr[1:0] * 8);
    a = {addr[15:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) ref_mem[a + 16'(i)] = shifted[i*8 +: 8];
    end
  endtask

  function automatic logic [31:0] random_word_addr(input logic upper);
    logic [31:0] r;
    r = $urandom;
    return MEM_BASE | {16'h0, upper, r[14:2], 2'b00};
  endfunction

  // each access task starts and ends 2 ns after a rising edge
  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data);
    ifu_araddr  = addr;
    ifu_arvalid = 1'b1;
    do @(negedge clock); while (!ifu_rvalid);
    data = ifu_rdata;
    @(posedge clock);
    #2;
    ifu_arvalid = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [7:0] strb,
                           output logic [31:0] data, output int cycles);
    lsu_araddr  = addr;
    lsu_rstrb   = strb;
    lsu_arvalid = 1'b1;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!lsu_rvalid);
    data = lsu_rdata;
    @(posedge clock);
    #2;
    lsu_arvalid = 1'b0;
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [7:0] strb);
    lsu_awaddr  = addr;
    lsu_wdata   = data;
    lsu_wstrb   = strb;
    lsu_awvalid = 1'b1;
    lsu_wvalid  = 1'b1;
    do @(negedge clock); while (!lsu_wready);
    @(posedge clock);
    #2;
    lsu_awvalid = 1'b0;
    lsu_wvalid  = 1'b0;
  endtask

  task automatic random_store(input logic upper, output logic [31:0] word_addr);
    logic [31:0] data;
    logic [7:0]  strb;
    logic [3:0]  lanes;
    int          off;
    int          nbytes;
    mem_map_pkg::access_width_t width;
    axi_pkg::axi_size_t         size;
    word_addr = random_word_addr(upper);
    data = $urandom;
    case ($urandom_range(2, 0))
      0: begin
        width  = mem_map_pkg::WIDTH_BYTE;
        size   = axi_pkg::SIZE_BYTE;
        strb   = 8'h01;
        nbytes = 1;
        off    = $urandom_range(3, 0);
      end
      1: begin
        width  = mem_map_pkg::WIDTH_HALF;
        size   = axi_pkg::SIZE_HALF;
        strb   = 8'h03;
        nbytes = 2;
        off    = 2 * $urandom_range(1, 0);
      end
      default: begin
        width  = mem_map_pkg::WIDTH_WORD;
        size   = axi_pkg::SIZE_WORD;
        strb   = 8'h0f;
        nbytes = 4;
        off    = 0;
      end
    endcase
    for (int i = 0; i < 4; i++) begin
      lanes[i] = (i >= off) && (i < off + nbytes);
    end
    store_word(word_addr + 32'(off), data, strb);
    assert (wstrb_seen == lanes)
      else flag_mismatch($sformatf("%s store at offset %0d gave wstrb %b, expected %b",
                                   width.name(), off, wstrb_seen, lanes));
    assert (aw_size_seen == size)
      else flag_mismatch($sformatf("%s store gave awsize %0d, expected %0d",
                                   width.name(), aw_size_seen, size));
    ref_store(word_addr + 32'(off), data, lanes);
  endtask

  task automatic finish_test(input string name, input int errs_at_start, input int requests);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %-12s %4d requests  ok", name, requests);
    end else begin
      tests_failed++;
      $display("test %-12s %4d requests  %0d check failures", name, requests,
               errors - errs_at_start);
    end
  endtask

  // bus monitor sampled mid cycle
  always @(negedge clock) begin
    if (reset) begin
      ar_open = 1'b0;
      aw_open = 1'b0;
      w_open  = 1'b0;
    end else begin
      if (ar_open) begin
        assert (arvalid) else flag_mismatch("arvalid dropped before arready");
      end
      if (aw_open) begin
        assert (awvalid) else flag_mismatch("awvalid dropped before awready");
      end
      if (w_open) begin
        assert (wvalid) else flag_mismatch("wvalid dropped before wready");
      end
      assert (rready && bready) else flag_mismatch("rready or bready is not held high");
      ar_open = arvalid && !arready;
      aw_open = awvalid && !awready;
      w_open  = wvalid && !wready;
      if (arvalid && arready) begin
        ar_count++;
        ar_size_seen = arsize;
        ar_addr_q.push_back(araddr);
        assert (arburst == axi_pkg::BURST_FIXED && arlen == 8'h00 && arid == 4'h0)
          else flag_mismatch("AR request is not a single beat with id zero");
      end
      if (awvalid && awready) begin
        aw_size_seen = awsize;
        assert (awburst == axi_pkg::BURST_FIXED && awlen == 8'h00 && awid == 4'h0)
          else flag_mismatch("AW request is not a single beat with id zero");
      end
      if (wvalid && wready) begin
        wstrb_seen = wstrb;
        assert (wlast) else flag_mismatch("wlast low on a single beat write");
      end
      if (ifu_rvalid || lsu_rvalid) begin
        assert (!bus_ifu_ready) else flag_mismatch("bus_ifu_ready high while a read returns");
      end
      if (ifu_rvalid) ifu_rcount++;
      if (lsu_rvalid) lsu_rcount++;
      if (lsu_wready) wready_count++;
    end
  end

  initial begin : watchdog
    repeat (`BUS_TIMEOUT_CYCLES * TOTAL_REQS) @(posedge clock);
    $display("watchdog expired, a request never completed");
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] fa;
    logic [31:0] la;
    logic [31:0] d1;
    logic [31:0] prev;
    logic [31:0] stored_q [$];
    int          cycles;
    int          errs0;
    int          n_ifu;
    int          n_lsu;
    int          n_wr;
    int          n_ar;
    void'($urandom(59851));
    reset       = 1'b1;
    delay_max   = 2'd1;
    ifu_araddr  = '0;
    ifu_arvalid = 1'b0;
    ifu_lock    = 1'b0;
    ifu_ready   = 1'b1;
    lsu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_rstrb   = 8'h0f;
    lsu_awaddr  = '0;
    lsu_awvalid = 1'b0;
    lsu_wdata   = '0;
    lsu_wstrb   = 8'h00;
    lsu_wvalid  = 1'b0;
    load_reference();
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b0;

    errs0 = errors;
    n_ifu = ifu_rcount;
    for (int n = 0; n < 200; n++) begin
      addr = random_word_addr(n[0]);
      assert (bus_ifu_ready) else flag_mismatch("bus_ifu_ready low with the arbiter idle");
      fetch_word(addr, data);
      assert (data == ref_word(addr))
        else flag_mismatch($sformatf("fetch %h gave %h, expected %h", addr, data, ref_word(addr)));
    end
    assert (ifu_rcount - n_ifu == 200)
      else flag_mismatch($sformatf("%0d fetch returns for 200 fetches", ifu_rcount - n_ifu));
    finish_test("fetch", errs0, 200);

    errs0 = errors;
    n_lsu = lsu_rcount;
    for (int n = 0; n < 30; n++) begin
      addr = random_word_addr(n[0]);
      load_word(addr, LOAD_STRB[n % 3], data, cycles);
      assert (data == ref_word(addr))
        else flag_mismatch($sformatf("load %h gave %h, expected %h", addr, data, ref_word(addr)));
      assert (ar_size_seen == LOAD_SIZE[n % 3])
        else flag_mismatch($sformatf("strobe %h gave arsize %0d", LOAD_STRB[n % 3], ar_size_seen));
    end
    assert (lsu_rcount - n_lsu == 30) else flag_mismatch("load return count is not 30");
    finish_test("load_width", errs0, 30);

    errs0 = errors;
    n_wr = wready_count;
    for (int n = 0; n < 40; n++) begin
      random_store(n[0], addr);
      load_word(addr, 8'h0f, data, cycles);
      assert (data == ref_word(addr))
        else flag_mismatch($sformatf("after store %h reads %h, expected %h",
                                     addr, data, ref_word(addr)));
    end
    assert (wready_count - n_wr == 40) else flag_mismatch("store done count is not 40");
    finish_test("store_align", errs0, 80);

    errs0 = errors;
    fa = random_word_addr(1'b0);
    la = random_word_addr(1'b1);
    ar_addr_q.delete();
    fork
      fetch_word(fa, d1);
      load_word(la, 8'h0f, data, cycles);
    join
    assert (ar_addr_q.size() == 2 && ar_addr_q[0] == fa && ar_addr_q[1] == la)
      else flag_mismatch("fetch was not issued ahead of the pending load");
    assert (d1 == ref_word(fa) && data == ref_word(la))
      else flag_mismatch("wrong data in the fetch and load race");
    ifu_lock = 1'b1;
    n_ar = ar_count;
    la = random_word_addr(1'b0);
    fork
      load_word(la, 8'h0f, data, cycles);
      begin
        repeat (12) begin
          @(negedge clock);
          assert (!arvalid && !lsu_rvalid) else flag_mismatch("load issued under ifu_lock");
        end
        @(posedge clock);
        #2;
        ifu_lock = 1'b0;
      end
    join
    assert (ar_count - n_ar == 1 && data == ref_word(la))
      else flag_mismatch("load after the lock dropped went wrong");
    finish_test("arbitration", errs0, 3);

    errs0 = errors;
    n_ar = ar_count;
    prev = '0;
    for (int n = 0; n < 10; n++) begin
      load_word(`BUS_CLINT_ADDR, 8'h0f, data, cycles);
      // idle cycle then the clint request then its answer
      assert (cycles == 3) else flag_mismatch($sformatf("timer load took %0d cycles", cycles));
      assert (data >= prev) else flag_mismatch($sformatf("mtime went back %h -> %h", prev, data));
      prev = data;
      load_word(`BUS_CLINT_ADDR_UP, 8'h0f, data, cycles);
      assert (data == 32'h0) else flag_mismatch($sformatf("mtime high word is %h", data));
    end
    assert (ar_count == n_ar) else flag_mismatch("a timer load reached the AR channel");
    finish_test("timer", errs0, 20);

    errs0 = errors;
    delay_max = 2'd3;
    n_lsu = ifu_rcount + lsu_rcount;
    n_wr = wready_count;
    stored_q.delete();
    fork
      begin : reader
        logic [31:0] ra;
        logic [31:0] rd;
        int          rc;
        for (int n = 0; n < 30; n++) begin
          ra = random_word_addr(1'b0);
          if ($urandom_range(1, 0) == 0) fetch_word(ra, rd);
          else load_word(ra, 8'h0f, rd, rc);
          assert (rd == ref_word(ra))
            else flag_mismatch($sformatf("read %0d of %h gave %h under stalls", n, ra, rd));
        end
      end
      begin : writer
        logic [31:0] wa;
        for (int n = 0; n < 30; n++) begin
          random_store(1'b1, wa);
          stored_q.push_back(wa);
        end
      end
    join
    foreach (stored_q[i]) begin
      load_word(stored_q[i], 8'h0f, data, cycles);
      assert (data == ref_word(stored_q[i]))
        else flag_mismatch($sformatf("stalled store to %h reads back %h", stored_q[i], data));
    end
    assert (ifu_rcount + lsu_rcount - n_lsu == 60) else flag_mismatch("read return count is off");
    assert (wready_count - n_wr == 30) else flag_mismatch("store done count is off");
    finish_test("backpressure", errs0, 90);

    $display("tests run %0d, tests failed %0d, check failures %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
axi_pkg.sv
mem_map_pkg.sv
clint.sv
read_arbiter.sv
store_channel.sv
bus_top.sv
axi_mem_model.sv
tb_bus.sv

//--- run_sim.sh
#!/bin/sh
# build tb_bus with Verilator, run it, grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_bus -f vlog.f -o tb_bus_sim \
    > build.log 2>&1 \
  && ./obj_dir/tb_bus_sim > sim.log 2>&1 \
  || echo "build or simulation stopped with an error, see build.log and sim.log"
if grep -q "Simulation passed" sim.log 2>/dev/null; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
